// ==== build.f ====
+incdir+logic
logic/rob_pkg.sv
logic/exec_pkg.sv
logic/rob_pointers.sv
logic/rob_entries.sv
logic/rob_operand_lookup.sv
logic/rob_top.sv
test/rob_tb.sv

// ==== logic/exec_pkg.sv ====
`include "rob_cfg.svh"

package exec_pkg;

    import rob_pkg::*;

    // value is the writeback port index, lower wins
    typedef enum logic [$clog2(`WB_PORTS)-1:0] {
        exec_alu  = 0,
        exec_mul  = 1,
        exec_div  = 2,
        exec_load = 3
    } exec_unit_e;

    typedef struct packed {
        logic                   valid;
        rob_tag_t               tag;
        logic [`WORD_WIDTH-1:0] value;
    } wb_result_t;

    typedef struct packed {
        logic                   valid;       // resolution done
        logic                   taken;
        logic [`PC_WIDTH-1:0]   target;
        logic                   link_valid;  // jal/jalr rd = pc+4
        logic [`WORD_WIDTH-1:0] link_value;
        rob_tag_t               tag;
    } br_result_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } operand_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`WORD_WIDTH-1:0] value;
    } operand_resp_t;

endpackage

// ==== logic/rob_cfg.svh ====
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// reorder buffer geometry
`define ROB_DEPTH       16
`define ROB_TAG_WIDTH   4   // log2 of depth

// datapath widths
`define WORD_WIDTH      32
`define PC_WIDTH        32
`define AREG_ADDR_WIDTH 5

`define WB_PORTS        4   // alu, mul, div, load
`define EXC_WIDTH       4

`endif

// ==== logic/rob_entries.sv ====
`include "rob_cfg.svh"

module rob_entries
    import rob_pkg::*;
    import exec_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  alloc_req_t                                alloc,
    input  rob_tag_t                                  tail_tag,
    input  rob_tag_t                                  head_tag,
    input  logic                                      empty,
    input  wb_result_t [`WB_PORTS-1:0]                wb,
    input  br_result_t                                br,
    output commit_t                                   commit,
    output logic                                      retire,
    output logic                                      flush,
    output logic [`ROB_DEPTH-1:0]                     ready_vec,
    output logic [`ROB_DEPTH-1:0][`WORD_WIDTH-1:0]    value_vec
);

    // fields written at allocation
    logic [`PC_WIDTH-1:0]        pc_mem       [`ROB_DEPTH];
    logic [`AREG_ADDR_WIDTH-1:0] dst_addr_mem [`ROB_DEPTH];
    logic                        dst_wen_mem  [`ROB_DEPTH];
    exc_code_e                   exc_mem      [`ROB_DEPTH];

    logic [`PC_WIDTH-1:0]        br_addr_mem  [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]       taken_vec;

    logic [`ROB_DEPTH-1:0]       wb_hit;     // any result for entry this cycle
    logic [`ROB_DEPTH-1:0]       taken_hit;

    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            wb_hit[i]    = (br.valid || br.link_valid) && (br.tag == rob_tag_t'(i));
            taken_hit[i] = br.valid && br.taken && (br.tag == rob_tag_t'(i));
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wb[p].valid && (wb[p].tag == rob_tag_t'(i)))
                    wb_hit[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            pc_mem[tail_tag]       <= alloc.pc;
            dst_addr_mem[tail_tag] <= alloc.dst_addr;
            dst_wen_mem[tail_tag]  <= alloc.dst_wen;
            exc_mem[tail_tag]      <= alloc.exc;
        end
        if (br.valid && br.taken)
            br_addr_mem[br.tag] <= br.target;
    end

    // result capture, later assignment wins so port 0 has priority
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (br.link_valid && (br.tag == rob_tag_t'(i)))
                value_vec[i] <= br.link_value;
            for (int p = `WB_PORTS - 1; p >= 0; p--) begin
                if (wb[p].valid && (wb[p].tag == rob_tag_t'(i)))
                    value_vec[i] <= wb[p].value;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_vec <= '0;
            taken_vec <= '0;
        end else if (flush) begin
            ready_vec <= '0;
            taken_vec <= '0;
        end else begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (alloc.valid && (tail_tag == rob_tag_t'(i))) begin
                    ready_vec[i] <= 1'b0;  // late result from a squashed op
                    taken_vec[i] <= 1'b0;
                end else if (retire && (head_tag == rob_tag_t'(i))) begin
                    ready_vec[i] <= 1'b0;
                end else if (wb_hit[i]) begin
                    ready_vec[i] <= 1'b1;
                    if (taken_hit[i])
                        taken_vec[i] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        commit.valid    = !empty && ready_vec[head_tag];
        commit.tag      = head_tag;
        commit.pc       = pc_mem[head_tag];
        commit.dst_addr = dst_addr_mem[head_tag];
        commit.dst_wen  = dst_wen_mem[head_tag];
        commit.value    = value_vec[head_tag];
        commit.br_taken = taken_vec[head_tag];
        commit.br_addr  = br_addr_mem[head_tag];
        commit.exc      = exc_mem[head_tag];
    end

    assign retire = commit.valid;  // no stall from the consumer
    assign flush  = retire && (commit.br_taken || (commit.exc != exc_none));

    // flush only happens with a retiring head and leaves the rob empty
    a_flush_empties: assert property (
        @(posedge clk) disable iff (!rst_n) flush |-> retire ##1 empty
    ) else $error("flush without retire or rob not empty afterwards");

endmodule

// ==== logic/rob_operand_lookup.sv ====
`include "rob_cfg.svh"

module rob_operand_lookup
    import rob_pkg::*;
    import exec_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  operand_req_t                              rs1_req,
    input  operand_req_t                              rs2_req,
    input  wb_result_t [`WB_PORTS-1:0]                wb,
    input  br_result_t                                br,
    input  logic [`ROB_DEPTH-1:0]                     ready_vec,
    input  logic [`ROB_DEPTH-1:0][`WORD_WIDTH-1:0]    value_vec,
    output operand_resp_t                             rs1_resp,
    output operand_resp_t                             rs2_resp
);

    operand_resp_t          rs1_next;
    operand_resp_t          rs2_next;
    logic                   rs1_valid_q;
    logic                   rs2_valid_q;
    logic [`WORD_WIDTH-1:0] rs1_value_q;
    logic [`WORD_WIDTH-1:0] rs2_value_q;

    // stored value first, then same cycle results
    function automatic operand_resp_t resolve(operand_req_t req);
        operand_resp_t resp;
        exec_unit_e    unit;
        logic          hit;
        resp = '0;
        unit = exec_alu;
        hit  = 1'b0;
        for (int p = `WB_PORTS - 1; p >= 0; p--) begin
            if (wb[p].valid && (wb[p].tag == req.tag)) begin
                hit  = 1'b1;
                unit = exec_unit_e'(p);
            end
        end
        if (!req.valid)
            resp = '0;
        else if (ready_vec[req.tag])
            resp = '{valid: 1'b1, value: value_vec[req.tag]};
        else if (hit)
            resp = '{valid: 1'b1, value: wb[unit].value};
        else if (br.link_valid && (br.tag == req.tag))
            resp = '{valid: 1'b1, value: br.link_value};  // link is last
        return resp;
    endfunction

    always_comb begin
        rs1_next = resolve(rs1_req);
        rs2_next = resolve(rs2_req);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs1_valid_q <= 1'b0;
            rs2_valid_q <= 1'b0;
        end else begin
            rs1_valid_q <= rs1_next.valid;
            rs2_valid_q <= rs2_next.valid;
        end
    end

    always_ff @(posedge clk) begin
        rs1_value_q <= rs1_next.value;
        rs2_value_q <= rs2_next.value;
    end

    assign rs1_resp = '{valid: rs1_valid_q, value: rs1_value_q};
    assign rs2_resp = '{valid: rs2_valid_q, value: rs2_value_q};

endmodule

// ==== logic/rob_pkg.sv ====
`include "rob_cfg.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_WIDTH-1:0] rob_tag_t;

    // decoder side exception codes
    typedef enum logic [`EXC_WIDTH-1:0] {
        exc_none             = `EXC_WIDTH'd0,
        exc_instr_misaligned = `EXC_WIDTH'd1,
        exc_illegal_instr    = `EXC_WIDTH'd2,
        exc_breakpoint       = `EXC_WIDTH'd3
    } exc_code_e;

    // one decoded instruction entering the rob
    typedef struct packed {
        logic                          valid;
        logic [`PC_WIDTH-1:0]          pc;
        logic [`AREG_ADDR_WIDTH-1:0]   dst_addr;
        logic                          dst_wen;
        exc_code_e                     exc;
    } alloc_req_t;

    // head entry as seen by the retire stage
    typedef struct packed {
        logic                          valid;
        rob_tag_t                      tag;
        logic [`PC_WIDTH-1:0]          pc;
        logic [`AREG_ADDR_WIDTH-1:0]   dst_addr;
        logic                          dst_wen;
        logic [`WORD_WIDTH-1:0]        value;
        logic                          br_taken;
        logic [`PC_WIDTH-1:0]          br_addr;   // redirect target
        exc_code_e                     exc;
    } commit_t;

endpackage

// ==== logic/rob_pointers.sv ====
`include "rob_cfg.svh"

module rob_pointers
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     retire,
    input  logic     flush,
    input  logic     alloc_valid,
    output rob_tag_t tail_tag,
    output rob_tag_t head_tag,
    output logic     full,
    output logic     empty
);

    // msb is the wrap bit
    logic [`ROB_TAG_WIDTH:0] head_ptr;
    logic [`ROB_TAG_WIDTH:0] tail_ptr;
    logic [`ROB_TAG_WIDTH:0] head_inc;

    assign head_inc = head_ptr + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (retire)
                head_ptr <= head_inc;
            if (flush)
                tail_ptr <= head_inc;  // drop everything younger than head
            else if (alloc_valid)
                tail_ptr <= tail_ptr + 1'b1;
        end
    end

    assign tail_tag = tail_ptr[`ROB_TAG_WIDTH-1:0];
    assign head_tag = head_ptr[`ROB_TAG_WIDTH-1:0];

    assign empty = (tail_ptr == head_ptr);
    assign full  = (tail_ptr[`ROB_TAG_WIDTH] != head_ptr[`ROB_TAG_WIDTH]) &&
                   (tail_tag == head_tag);

    // decoder has to stall on full
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(alloc_valid && full)
    ) else $error("allocation while rob full");

    a_no_retire_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !(retire && empty)
    ) else $error("retire while rob empty");

endmodule

// ==== logic/rob_top.sv ====
`include "rob_cfg.svh"

module rob_top
    import rob_pkg::*;
    import exec_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  alloc_req_t                 alloc,
    output rob_tag_t                   alloc_tag,
    input  wb_result_t [`WB_PORTS-1:0] wb,
    input  br_result_t                 br,
    input  operand_req_t               rs1_req,
    input  operand_req_t               rs2_req,
    output operand_resp_t              rs1_resp,
    output operand_resp_t              rs2_resp,
    output commit_t                    commit,
    output logic                       full,
    output logic                       empty
);

    rob_tag_t                                head_tag;
    logic                                    retire;
    logic                                    flush;
    logic [`ROB_DEPTH-1:0]                   ready_vec;
    logic [`ROB_DEPTH-1:0][`WORD_WIDTH-1:0]  value_vec;

    rob_pointers rob_pointers_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .retire      (retire),
        .flush       (flush),
        .alloc_valid (alloc.valid),
        .tail_tag    (alloc_tag),   // tail is the next tag handed out
        .head_tag    (head_tag),
        .full        (full),
        .empty       (empty)
    );

    rob_entries rob_entries_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc     (alloc),
        .tail_tag  (alloc_tag),
        .head_tag  (head_tag),
        .empty     (empty),
        .wb        (wb),
        .br        (br),
        .commit    (commit),
        .retire    (retire),
        .flush     (flush),
        .ready_vec (ready_vec),
        .value_vec (value_vec)
    );

    rob_operand_lookup rob_operand_lookup_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_req   (rs1_req),
        .rs2_req   (rs2_req),
        .wb        (wb),
        .br        (br),
        .ready_vec (ready_vec),
        .value_vec (value_vec),
        .rs1_resp  (rs1_resp),
        .rs2_resp  (rs2_resp)
    );

endmodule

// ==== test/rob_tb.sv ====
`include "rob_cfg.svh"

module rob_tb
    import rob_pkg::*;
    import exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_STEPS = 64;

    logic                       clk;
    logic                       rst_n;
    alloc_req_t                 alloc;
    rob_tag_t                   alloc_tag;
    wb_result_t [`WB_PORTS-1:0] wb;
    br_result_t                 br;
    operand_req_t               rs1_req;
    operand_req_t               rs2_req;
    operand_resp_t              rs1_resp;
    operand_resp_t              rs2_resp;
    commit_t                    commit;
    logic                       full;
    logic                       empty;

    string       step_name [MAX_STEPS];
    string       step_op   [MAX_STEPS];
    string       step_chk  [MAX_STEPS];
    logic [31:0] step_arg  [MAX_STEPS][4];
    logic [31:0] step_exp  [MAX_STEPS][6];
    int          n_steps     = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;  // set once the test file is read
    logic        test_ok;

    // allocation fields per tag, as driven
    logic [`PC_WIDTH-1:0]        model_pc  [`ROB_DEPTH];
    logic [`AREG_ADDR_WIDTH-1:0] model_dst [`ROB_DEPTH];
    logic                        model_wen [`ROB_DEPTH];
    rob_tag_t                    model_tail = '0;

    rob_top rob_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc     (alloc),
        .alloc_tag (alloc_tag),
        .wb        (wb),
        .br        (br),
        .rs1_req   (rs1_req),
        .rs2_req   (rs2_req),
        .rs1_resp  (rs1_resp),
        .rs2_resp  (rs2_resp),
        .commit    (commit),
        .full      (full),
        .empty     (empty)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic load_tests();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("test/rob_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open test/rob_tests.txt");
            return;
        end
        while (!$feof(fd) && n_steps < MAX_STEPS) begin
            line = "";
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() < 2 || line[0] == "#")
                continue;  // blank or column notes
            cnt = $sscanf(line, "%s %s %h %h %h %h %s %h %h %h %h %h %h",
                          step_name[n_steps], step_op[n_steps],
                          step_arg[n_steps][0], step_arg[n_steps][1],
                          step_arg[n_steps][2], step_arg[n_steps][3],
                          step_chk[n_steps],
                          step_exp[n_steps][0], step_exp[n_steps][1],
                          step_exp[n_steps][2], step_exp[n_steps][3],
                          step_exp[n_steps][4], step_exp[n_steps][5]);
            if (cnt == 13)
                n_steps++;
            else begin
                $display("malformed line in test file: %s", line);
                fail_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        alloc   = '0;
        wb      = '0;
        br      = '0;
        rs1_req = '0;
        rs2_req = '0;
    endtask

    task automatic check_commit(string name, commit_t exp, commit_t act);
        logic ok;
        ok = (act.valid === exp.valid);
        if (exp.valid)
            ok = ok && (act.tag === exp.tag) && (act.pc === exp.pc) &&
                 (act.dst_addr === exp.dst_addr) && (act.dst_wen === exp.dst_wen) &&
                 (act.value === exp.value) && (act.br_taken === exp.br_taken) &&
                 (act.exc === exp.exc) && (!exp.br_taken || act.br_addr === exp.br_addr);
        if (!ok) begin
            $write("Fail %s commit expected valid=%0b tag=%0d pc=%h dst=%0d wen=%0b",
                   name, exp.valid, exp.tag, exp.pc, exp.dst_addr, exp.dst_wen);
            $write(" value=%h taken=%0b addr=%h exc=%0d",
                   exp.value, exp.br_taken, exp.br_addr, exp.exc);
            $write(" actual valid=%0b tag=%0d pc=%h dst=%0d wen=%0b",
                   act.valid, act.tag, act.pc, act.dst_addr, act.dst_wen);
            $display(" value=%h taken=%0b addr=%h exc=%0d",
                     act.value, act.br_taken, act.br_addr, act.exc);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_operand(string name, string port, operand_resp_t exp,
                                 operand_resp_t act);
        // value only matters when the response is valid
        if (act.valid !== exp.valid || (exp.valid && act.value !== exp.value)) begin
            $display("Fail %s %s expected valid=%0b value=%h actual valid=%0b value=%h",
                     name, port, exp.valid, exp.value, act.valid, act.value);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_status(string name, logic exp_full, logic exp_empty,
                                logic act_full, logic act_empty);
        if (act_full !== exp_full || act_empty !== exp_empty) begin
            $display("Fail %s status expected full=%0b empty=%0b actual full=%0b empty=%0b",
                     name, exp_full, exp_empty, act_full, act_empty);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_tag(string name, rob_tag_t exp, rob_tag_t act);
        if (act !== exp) begin
            $display("Fail %s alloc tag expected %0d actual %0d", name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    // entered and left 2 ns after a rising edge
    task automatic run_step(int s);
        logic [31:0]   a [4];
        logic [31:0]   e [6];
        int            count;
        commit_t       exp_commit;
        operand_resp_t exp_rs1;
        operand_resp_t exp_rs2;
        for (int k = 0; k < 4; k++)
            a[k] = step_arg[s][k];
        for (int k = 0; k < 6; k++)
            e[k] = step_exp[s][k];
        test_ok = 1'b1;
        count = (step_op[s] == "allocn" || step_op[s] == "wbn") ? int'(a[0]) : 1;
        for (int i = 0; i < count; i++) begin
            if (i > 0) begin
                @(posedge clk);
                #2;
            end
            drive_idle();
            case (step_op[s])
                "alloc", "allocn": begin
                    alloc.valid    = 1'b1;
                    alloc.pc       = (step_op[s] == "alloc") ? a[0] : a[1] + 4 * i;
                    alloc.dst_addr = (step_op[s] == "alloc") ? a[1][4:0] : '0;
                    alloc.dst_wen  = (step_op[s] == "alloc") && (a[1] != 0);
                    alloc.exc      = (step_op[s] == "alloc") ? exc_code_e'(a[2][3:0]) : exc_none;
                    if (step_op[s] == "alloc" && step_chk[s] == "tag")
                        model_tail = rob_tag_t'(e[0]);  // tag the file expects
                    model_pc[model_tail]  = alloc.pc;
                    model_dst[model_tail] = alloc.dst_addr;
                    model_wen[model_tail] = alloc.dst_wen;
                    model_tail = model_tail + 1'b1;
                end
                "wb": begin
                    wb[a[0][1:0]].valid = 1'b1;
                    wb[a[0][1:0]].tag   = rob_tag_t'(a[1]);
                    wb[a[0][1:0]].value = a[2];
                end
                "wbn": begin
                    wb[0].valid = 1'b1;
                    wb[0].tag   = rob_tag_t'(a[1] + i);  // wraps with the depth
                    wb[0].value = a[2] + i;
                end
                "br": begin
                    br.valid      = 1'b1;
                    br.tag        = rob_tag_t'(a[0]);
                    br.taken      = a[1][0];
                    br.target     = a[2];
                    br.link_valid = (a[3] != 0);
                    br.link_value = a[3];
                end
                "lookup": begin
                    rs1_req.valid = 1'b1;
                    rs1_req.tag   = rob_tag_t'(a[0]);
                    rs2_req.valid = 1'b1;
                    rs2_req.tag   = rob_tag_t'(a[1]);
                    if (a[2] != 0) begin  // alu result for rs1 in the same cycle
                        wb[int'(exec_alu)].valid = 1'b1;
                        wb[int'(exec_alu)].tag   = rob_tag_t'(a[0]);
                        wb[int'(exec_alu)].value = a[2];
                    end
                end
                "idle": ;
                default: begin
                    $display("%s uses an unknown operation %s", step_name[s], step_op[s]);
                    test_ok = 1'b0;
                end
            endcase
        end
        #1;
        if (step_chk[s] == "tag")
            check_tag(step_name[s], rob_tag_t'(e[0]), alloc_tag);
        @(posedge clk);
        #1;
        exp_commit          = '0;
        exp_commit.valid    = e[0][0];
        exp_commit.tag      = rob_tag_t'(e[1]);
        exp_commit.pc       = model_pc[exp_commit.tag];
        exp_commit.dst_addr = model_dst[exp_commit.tag];
        exp_commit.dst_wen  = model_wen[exp_commit.tag];
        exp_commit.value    = e[2];
        exp_commit.br_taken = e[3][0];
        exp_commit.br_addr  = e[4];
        exp_commit.exc      = exc_code_e'(e[5][3:0]);
        exp_rs1.valid       = e[0][0];
        exp_rs1.value       = e[1];
        exp_rs2.valid       = e[2][0];
        exp_rs2.value       = e[3];
        case (step_chk[s])
            "commit":  check_commit(step_name[s], exp_commit, commit);
            "operand": begin
                check_operand(step_name[s], "rs1", exp_rs1, rs1_resp);
                check_operand(step_name[s], "rs2", exp_rs2, rs2_resp);
            end
            "status":  check_status(step_name[s], e[0][0], e[1][0], full, empty);
            "tag":     ;
            default: begin
                $display("%s asks for an unknown check %s", step_name[s], step_chk[s]);
                test_ok = 1'b0;
            end
        endcase
        #1;
    endtask

    initial begin
        rst_n = 1'b0;
        drive_idle();
        load_tests();
        cycle_limit = n_steps * 8 + 50;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        if (n_steps == 0) begin
            $display("no test steps were read from test/rob_tests.txt");
            fail_count++;
        end
        for (int s = 0; s < n_steps; s++) begin
            run_step(s);
            if (test_ok) begin
                pass_count++;
                $display("%-14s ok", step_name[s]);
            end else begin
                fail_count++;
                $display("%-14s did not match", step_name[s]);
            end
        end
        drive_idle();
        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== test/rob_tests.txt ====
# columns: name op a0 a1 a2 a3 check e0 e1 e2 e3 e4 e5, numbers in hex
# commit e: valid tag value taken target exc; operand e: rs1 valid value, rs2 valid value
reset_status   idle    0   0   0    0    status   0 1 0    0 0  0
reset_commit   idle    0   0   0    0    commit   0 0 0    0 0  0
reset_operand  idle    0   0   0    0    operand  0 0 0    0 0  0
alloc_a        alloc   100 1   0    0    tag      0 0 0    0 0  0
alloc_b        alloc   104 2   0    0    tag      1 0 0    0 0  0
alloc_c        alloc   108 3   0    0    tag      2 0 0    0 0  0
wb_c           wb      1   2   cc   0    commit   0 0 0    0 0  0
wb_a           wb      2   0   aa   0    commit   1 0 aa   0 0  0
wb_b           wb      3   1   bb   0    commit   1 1 bb   0 0  0
drain_c        idle    0   0   0    0    commit   1 2 cc   0 0  0
drain_end      idle    0   0   0    0    status   0 1 0    0 0  0
fill_all       allocn  10  200 0    0    status   1 0 0    0 0  0
drain_all      wbn     10  3   1000 0    commit   1 2 100f 0 0  0
drained        idle    0   0   0    0    status   0 1 0    0 0  0
br_alloc       alloc   300 0   0    0    tag      3 0 0    0 0  0
br_young1      alloc   304 5   0    0    tag      4 0 0    0 0  0
br_young2      alloc   308 6   0    0    tag      5 0 0    0 0  0
br_young_wb    wb      0   4   44   0    commit   0 0 0    0 0  0
br_taken       br      3   1   80   304  commit   1 3 304  1 80 0
br_flushed     idle    0   0   0    0    status   0 1 0    0 0  0
exc_alloc      alloc   400 7   2    0    tag      4 0 0    0 0  0
exc_young      alloc   404 8   0    0    tag      5 0 0    0 0  0
exc_young_wb   wb      1   5   55   0    commit   0 0 0    0 0  0
exc_wb         wb      0   4   77   0    commit   1 4 77   0 0  2
exc_flushed    idle    0   0   0    0    status   0 1 0    0 0  0
lk_alloc0      alloc   500 9   0    0    tag      5 0 0    0 0  0
lk_alloc1      alloc   504 a   0    0    tag      6 0 0    0 0  0
lk_alloc2      alloc   508 b   0    0    tag      7 0 0    0 0  0
lk_wb          wb      1   6   666  0    commit   0 0 0    0 0  0
lk_ready       lookup  6   7   0    0    operand  1 666 0  0 0  0
lk_bypass      lookup  7   5   777  0    operand  1 777 0  0 0  0
lk_head        wb      0   5   555  0    commit   1 5 555  0 0  0
